// ==== logic/prf_cfg_pkg.sv ====
/* prf config package
   sizes, default parameter values and the register data type */

package prf_cfg_pkg;

	//////////////////////////////
	// data path
	//////////////////////////////

	localparam int DATA_W = 64; // width of one physical register

	typedef logic [DATA_W-1:0] data_t; // one register value as it travels on cdb and read ports

	//////////////////////////////
	// default sizing
	//////////////////////////////

	// default number of physical registers, index width follows as clog2 of this
	localparam int PRF_SIZE_DEF = 64;

	// default slot of the hard-wired zero register
	localparam int ZERO_IDX_DEF = 48; // must stay below the entry count

endpackage

// ==== logic/prf_state_pkg.sv ====
/* prf entry state package
   life cycle of one physical register */

package prf_state_pkg;

	// an entry moves free -> pending on rename, pending -> ready on a cdb write
	// and back to free on retire or flush
	typedef enum logic [1:0] {
		ST_FREE    = 2'b00, // sitting on the free list
		ST_PENDING = 2'b01, // handed out by rename, result not produced yet
		ST_READY   = 2'b10  // value written and readable
	} entry_state_e;

endpackage

// ==== logic/prf_alloc.sv ====
/* prf free-entry picker
   hands out the two lowest free physical registers to the rename ports */

module prf_alloc #(
	parameter int PRF_SIZE = prf_cfg_pkg::PRF_SIZE_DEF,
	parameter int ZERO_IDX = prf_cfg_pkg::ZERO_IDX_DEF
)(
	input  logic                        alloc_req1,   // rename port 1 wants a register
	input  logic                        alloc_req2,   // rename port 2 wants a register
	input  logic [PRF_SIZE-1:0]         free_vec,     // one bit per entry on the free list

	output logic                        alloc_valid1,
	output logic [$clog2(PRF_SIZE)-1:0] alloc_idx1,
	output logic                        alloc_valid2,
	output logic [$clog2(PRF_SIZE)-1:0] alloc_idx2,
	output logic [PRF_SIZE-1:0]         grant_vec,    // entries that turn pending at the next edge
	output logic                        prf_full      // nothing left to hand out
);

	localparam int IDX_W = $clog2(PRF_SIZE);

	typedef logic [PRF_SIZE-1:0] vec_t;

	// the zero register is kept out of the scan so a stray free bit can never rename it
	localparam vec_t ZERO_BIT = vec_t'(1) << ZERO_IDX;

	vec_t avail;     // free entries that may be handed out
	vec_t pick1;     // lowest free entry, one-hot
	vec_t pick2;     // next lowest free entry, one-hot
	vec_t grant1;    // what port 1 actually receives
	vec_t grant2;    // what port 2 actually receives

	// two's complement trick, v & -v keeps only the lowest set bit
	function automatic vec_t lowest_one(input vec_t v);
		return v & (~v + vec_t'(1));
	endfunction

	// one-hot to binary, an all-zero input gives index zero
	function automatic logic [IDX_W-1:0] onehot_idx(input vec_t oh);
		logic [IDX_W-1:0] idx;
		idx = '0;
		for (int i = 0; i < PRF_SIZE; i++)
		begin
			if (oh[i])
				idx = idx | IDX_W'(i);
		end
		return idx;
	endfunction

	//////////////////////////////
	// scans
	//////////////////////////////

	assign avail = free_vec & ~ZERO_BIT;
	assign pick1 = lowest_one(avail);
	assign pick2 = lowest_one(avail & ~pick1); // second scan with the first pick masked out

	//////////////////////////////
	// steering to the ports
	//////////////////////////////

	// port 1 always takes the lowest, port 2 takes the lowest only when it asks alone
	assign grant1 = alloc_req1 ? pick1 : '0;
	assign grant2 = alloc_req2 ? (alloc_req1 ? pick2 : pick1) : '0;

	assign alloc_valid1 = |grant1; // low when no request or nothing free
	assign alloc_idx1   = onehot_idx(grant1);
	assign alloc_valid2 = |grant2;
	assign alloc_idx2   = onehot_idx(grant2);

	assign grant_vec = grant1 | grant2;
	assign prf_full  = ~|avail;

	// two rename ports must never be given the same physical register
	a_distinct_idx: assert final (!(alloc_valid1 && alloc_valid2) || alloc_idx1 != alloc_idx2)
		else $error("prf_alloc: both ports granted entry %0d", alloc_idx1);

endmodule

// ==== logic/prf_entries.sv ====
/* prf register storage
   per-entry state and value, updated by renames, cdb results, retire frees and flushes */

module prf_entries #(
	parameter int PRF_SIZE = prf_cfg_pkg::PRF_SIZE_DEF,
	parameter int ZERO_IDX = prf_cfg_pkg::ZERO_IDX_DEF
)(
	input  logic                        clock,
	input  logic                        reset,

	input  logic [PRF_SIZE-1:0]         grant_vec,   // entries picked for rename this cycle

	input  logic                        cdb1_valid,
	input  logic [$clog2(PRF_SIZE)-1:0] cdb1_tag,
	input  prf_cfg_pkg::data_t          cdb1_value,
	input  logic                        cdb2_valid,
	input  logic [$clog2(PRF_SIZE)-1:0] cdb2_tag,
	input  prf_cfg_pkg::data_t          cdb2_value,

	input  logic                        free1_valid, // retire frees, up to two a cycle
	input  logic [$clog2(PRF_SIZE)-1:0] free1_idx,
	input  logic                        free2_valid,
	input  logic [$clog2(PRF_SIZE)-1:0] free2_idx,

	input  logic                        flush_valid, // mispredict recovery
	input  logic [PRF_SIZE-1:0]         flush_list,  // every set bit goes back to the free list

	output logic [PRF_SIZE-1:0]         free_vec,
	output logic [PRF_SIZE-1:0]         ready_vec,
	output prf_cfg_pkg::data_t          data_arr [PRF_SIZE]
);

	import prf_cfg_pkg::*;
	import prf_state_pkg::*;

	localparam int IDX_W = $clog2(PRF_SIZE);

	entry_state_e state [PRF_SIZE]; // life cycle of each physical register

	//////////////////////////////
	// per-entry storage
	//////////////////////////////

	for (genvar i = 0; i < PRF_SIZE; i++)
	begin : g_entry

		assign free_vec[i]  = (state[i] == ST_FREE);
		assign ready_vec[i] = (state[i] == ST_READY);

		if (i == ZERO_IDX)
		begin : g_zero
			// loaded once by reset and never touched again
			// so reads of it always see a ready zero
			always_ff @(posedge clock)
			begin
				if (reset)
				begin
					state[i]    <= ST_READY;
					data_arr[i] <= '0;
				end
			end
		end
		else
		begin : g_reg
			logic do_free;  // a retire slot or the flush list names this entry
			logic cdb1_hit;
			logic cdb2_hit;
			logic do_write; // a result arrives for an entry that is waiting on it

			assign do_free = (free1_valid && free1_idx == IDX_W'(i)) ||
				(free2_valid && free2_idx == IDX_W'(i)) ||
				(flush_valid && flush_list[i]);

			assign cdb1_hit = cdb1_valid && (cdb1_tag == IDX_W'(i));
			assign cdb2_hit = cdb2_valid && (cdb2_tag == IDX_W'(i));

			// writes to free or already ready entries are dropped here
			assign do_write = (cdb1_hit || cdb2_hit) && (state[i] == ST_PENDING);

			always_ff @(posedge clock)
			begin
				if (reset)
					state[i] <= ST_FREE;
				else if (do_free)
					state[i] <= ST_FREE;    // free beats a same-cycle write or grant
				else if (do_write)
					state[i] <= ST_READY;
				else if (grant_vec[i] && state[i] == ST_FREE)
					state[i] <= ST_PENDING; // renamed, now waiting for its producer
			end

			// value only moves together with the pending -> ready step
			always_ff @(posedge clock)
			begin
				if (do_write && !do_free)
					data_arr[i] <= cdb2_hit ? cdb2_value : cdb1_value; // cdb2 wins a shared tag
			end
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	// the picker must only hand out entries this block still has on the free list
	a_grant_on_free: assert property (@(posedge clock) disable iff (reset)
		(grant_vec & ~free_vec) == '0)
		else $error("prf_entries: grant on non-free entry, grant=%h free=%h",
			grant_vec, free_vec);

	// zero register keeps its ready state for the whole run once reset has passed
	a_zero_ready: assert property (@(posedge clock) disable iff (reset)
		state[ZERO_IDX] == ST_READY)
		else $error("prf_entries: zero register left ST_READY");

endmodule

// ==== logic/prf_read.sv ====
/* prf read ports
   four operand reads returning value or tag, plus the retire writeback read */

module prf_read #(
	parameter int PRF_SIZE = prf_cfg_pkg::PRF_SIZE_DEF
)(
	input  logic [PRF_SIZE-1:0]         ready_vec,            // entries holding a valid value
	input  prf_cfg_pkg::data_t          data_arr [PRF_SIZE],

	input  logic [$clog2(PRF_SIZE)-1:0] opa1_idx,             // operands of instruction 1
	input  logic [$clog2(PRF_SIZE)-1:0] opb1_idx,
	input  logic [$clog2(PRF_SIZE)-1:0] opa2_idx,             // operands of instruction 2
	input  logic [$clog2(PRF_SIZE)-1:0] opb2_idx,
	input  logic [$clog2(PRF_SIZE)-1:0] wb_idx,               // register being retired

	output prf_cfg_pkg::data_t          opa1_value,
	output logic                        opa1_valid,
	output prf_cfg_pkg::data_t          opb1_value,
	output logic                        opb1_valid,
	output prf_cfg_pkg::data_t          opa2_value,
	output logic                        opa2_valid,
	output prf_cfg_pkg::data_t          opb2_value,
	output logic                        opb2_valid,
	output prf_cfg_pkg::data_t          wb_value
);

	import prf_cfg_pkg::*;

	localparam int IDX_W = $clog2(PRF_SIZE);

	logic wb_ready; // retiring entry has its value

	// an index past the last entry can only come from a non power of two size
	// and reads as not ready
	function automatic logic is_ready(input logic [PRF_SIZE-1:0] rdy,
		input logic [IDX_W-1:0] idx);
		return (idx < PRF_SIZE) && rdy[idx];
	endfunction

	// a ready entry gives its value, otherwise the tag goes back zero-extended
	// so the reservation station can wait on it
	function automatic data_t operand_mux(input logic ready, input data_t value,
		input logic [IDX_W-1:0] idx);
		return ready ? value : data_t'(idx);
	endfunction

	//////////////////////////////
	// operand ports
	//////////////////////////////

	assign opa1_valid = is_ready(ready_vec, opa1_idx);
	assign opa1_value = operand_mux(opa1_valid, data_arr[opa1_idx], opa1_idx);

	assign opb1_valid = is_ready(ready_vec, opb1_idx);
	assign opb1_value = operand_mux(opb1_valid, data_arr[opb1_idx], opb1_idx);

	assign opa2_valid = is_ready(ready_vec, opa2_idx);
	assign opa2_value = operand_mux(opa2_valid, data_arr[opa2_idx], opa2_idx);

	assign opb2_valid = is_ready(ready_vec, opb2_idx);
	assign opb2_value = operand_mux(opb2_valid, data_arr[opb2_idx], opb2_idx);

	//////////////////////////////
	// writeback port
	//////////////////////////////

	// retire wants the value only, a not-ready entry reads as zero
	assign wb_ready = is_ready(ready_vec, wb_idx);
	assign wb_value = wb_ready ? data_arr[wb_idx] : '0;

endmodule

// ==== logic/prf_top.sv ====
/* physical register file top
   rename allocation, cdb capture, operand and writeback reads for one thread */

module prf_top #(
	parameter int PRF_SIZE = prf_cfg_pkg::PRF_SIZE_DEF,
	parameter int ZERO_IDX = prf_cfg_pkg::ZERO_IDX_DEF
)(
	input  logic                        clock,
	input  logic                        reset,

	// rename
	input  logic                        alloc_req1,
	input  logic                        alloc_req2,
	output logic                        alloc_valid1,
	output logic [$clog2(PRF_SIZE)-1:0] alloc_idx1,
	output logic                        alloc_valid2,
	output logic [$clog2(PRF_SIZE)-1:0] alloc_idx2,
	output logic                        prf_full,

	// result buses
	input  logic                        cdb1_valid,
	input  logic [$clog2(PRF_SIZE)-1:0] cdb1_tag,
	input  prf_cfg_pkg::data_t          cdb1_value,
	input  logic                        cdb2_valid,
	input  logic [$clog2(PRF_SIZE)-1:0] cdb2_tag,
	input  prf_cfg_pkg::data_t          cdb2_value,

	// retire and mispredict recovery
	input  logic                        free1_valid,
	input  logic [$clog2(PRF_SIZE)-1:0] free1_idx,
	input  logic                        free2_valid,
	input  logic [$clog2(PRF_SIZE)-1:0] free2_idx,
	input  logic                        flush_valid,
	input  logic [PRF_SIZE-1:0]         flush_list,

	// reads
	input  logic [$clog2(PRF_SIZE)-1:0] opa1_idx,
	input  logic [$clog2(PRF_SIZE)-1:0] opb1_idx,
	input  logic [$clog2(PRF_SIZE)-1:0] opa2_idx,
	input  logic [$clog2(PRF_SIZE)-1:0] opb2_idx,
	input  logic [$clog2(PRF_SIZE)-1:0] wb_idx,
	output prf_cfg_pkg::data_t          opa1_value,
	output logic                        opa1_valid,
	output prf_cfg_pkg::data_t          opb1_value,
	output logic                        opb1_valid,
	output prf_cfg_pkg::data_t          opa2_value,
	output logic                        opa2_valid,
	output prf_cfg_pkg::data_t          opb2_value,
	output logic                        opb2_valid,
	output prf_cfg_pkg::data_t          wb_value
);

	import prf_cfg_pkg::*;

	logic [PRF_SIZE-1:0] grant_vec;            // picker -> storage, entries to mark pending
	logic [PRF_SIZE-1:0] free_vec;             // storage -> picker
	logic [PRF_SIZE-1:0] ready_vec;            // storage -> read ports
	data_t               data_arr [PRF_SIZE];  // storage -> read ports

	prf_alloc #(
		.PRF_SIZE (PRF_SIZE),
		.ZERO_IDX (ZERO_IDX)
	) alloc_i (
		.alloc_req1   (alloc_req1),
		.alloc_req2   (alloc_req2),
		.free_vec     (free_vec),
		.alloc_valid1 (alloc_valid1),
		.alloc_idx1   (alloc_idx1),
		.alloc_valid2 (alloc_valid2),
		.alloc_idx2   (alloc_idx2),
		.grant_vec    (grant_vec),
		.prf_full     (prf_full)
	);

	prf_entries #(
		.PRF_SIZE (PRF_SIZE),
		.ZERO_IDX (ZERO_IDX)
	) entries_i (
		.clock       (clock),
		.reset       (reset),
		.grant_vec   (grant_vec),
		.cdb1_valid  (cdb1_valid),
		.cdb1_tag    (cdb1_tag),
		.cdb1_value  (cdb1_value),
		.cdb2_valid  (cdb2_valid),
		.cdb2_tag    (cdb2_tag),
		.cdb2_value  (cdb2_value),
		.free1_valid (free1_valid),
		.free1_idx   (free1_idx),
		.free2_valid (free2_valid),
		.free2_idx   (free2_idx),
		.flush_valid (flush_valid),
		.flush_list  (flush_list),
		.free_vec    (free_vec),
		.ready_vec   (ready_vec),
		.data_arr    (data_arr)
	);

	prf_read #(
		.PRF_SIZE (PRF_SIZE)
	) read_i (
		.ready_vec  (ready_vec),
		.data_arr   (data_arr),
		.opa1_idx   (opa1_idx),
		.opb1_idx   (opb1_idx),
		.opa2_idx   (opa2_idx),
		.opb2_idx   (opb2_idx),
		.wb_idx     (wb_idx),
		.opa1_value (opa1_value),
		.opa1_valid (opa1_valid),
		.opb1_value (opb1_value),
		.opb1_valid (opb1_valid),
		.opa2_value (opa2_value),
		.opa2_valid (opa2_valid),
		.opb2_value (opb2_value),
		.opb2_valid (opb2_valid),
		.wb_value   (wb_value)
	);

endmodule

// ==== dv/tb_prf_top.sv ====
/* prf testbench
   directed and random stimulus against a cycle model of the register file */

module tb_prf_top;

	timeunit 1ns;
	timeprecision 1ps;

	import prf_cfg_pkg::*;
	import prf_state_pkg::*;

	localparam int PRF_SIZE        = PRF_SIZE_DEF;
	localparam int ZERO_IDX        = ZERO_IDX_DEF;
	localparam int IDX_W           = $clog2(PRF_SIZE);
	localparam int RESET_CYCLES    = 16;
	localparam int DIRECTED_CYCLES = 100; // the directed part needs about half of this
	localparam int RAND_CYCLES     = 2000;
	localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES;

	logic clock;
	logic reset;
	logic alloc_req1, alloc_req2, alloc_valid1, alloc_valid2, prf_full;
	logic [IDX_W-1:0] alloc_idx1, alloc_idx2;
	logic cdb1_valid, cdb2_valid, free1_valid, free2_valid, flush_valid;
	logic [IDX_W-1:0] cdb1_tag, cdb2_tag, free1_idx, free2_idx;
	data_t cdb1_value, cdb2_value;
	logic [PRF_SIZE-1:0] flush_list;
	logic [IDX_W-1:0] opa1_idx, opb1_idx, opa2_idx, opb2_idx, wb_idx;
	data_t opa1_value, opb1_value, opa2_value, opb2_value, wb_value;
	logic opa1_valid, opb1_valid, opa2_valid, opb2_valid;

	entry_state_e m_state [PRF_SIZE]; // model of every entry after the next edge
	data_t        m_data  [PRF_SIZE];
	int errors;
	int checks;

	prf_top #(.PRF_SIZE(PRF_SIZE), .ZERO_IDX(ZERO_IDX)) dut_i (.*);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock; // 10 ns period
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	// lowest free entry to port 1, next lowest to port 2 when both ask
	function automatic void expected_alloc(input logic req1, input logic req2,
		output logic v1, output logic [IDX_W-1:0] i1,
		output logic v2, output logic [IDX_W-1:0] i2, output logic full);
		int first;
		int second;
		first = -1;
		second = -1;
		for (int i = 0; i < PRF_SIZE; i++)
		begin
			if (i != ZERO_IDX && m_state[i] == ST_FREE)
			begin
				if (first < 0)
					first = i;
				else if (second < 0)
					second = i;
			end
		end
		full = (first < 0);
		v1 = req1 && first >= 0;
		i1 = v1 ? IDX_W'(first) : '0;
		v2 = req2 && (req1 ? second >= 0 : first >= 0); // port 2 alone takes the lowest
		i2 = !v2 ? '0 : (req1 ? IDX_W'(second) : IDX_W'(first));
	endfunction

	// ready gives the value, anything else gives the tag with valid low
	function automatic void expected_read(input logic [IDX_W-1:0] idx,
		output data_t value, output logic valid);
		valid = (m_state[idx] == ST_READY);
		value = valid ? m_data[idx] : data_t'(idx);
	endfunction

	function automatic void model_reset();
		for (int i = 0; i < PRF_SIZE; i++)
		begin
			m_state[i] = (i == ZERO_IDX) ? ST_READY : ST_FREE;
			m_data[i]  = '0;
		end
	endfunction

	// free beats write, write beats grant, the zero register is left alone
	function automatic void model_update(input logic v1, input logic [IDX_W-1:0] i1,
		input logic v2, input logic [IDX_W-1:0] i2);
		logic do_free;
		logic hit1;
		logic hit2;
		for (int i = 0; i < PRF_SIZE; i++)
		begin
			do_free = (free1_valid && free1_idx == i) || (free2_valid && free2_idx == i) ||
				(flush_valid && flush_list[i]);
			hit1 = cdb1_valid && cdb1_tag == i;
			hit2 = cdb2_valid && cdb2_tag == i;
			if (i == ZERO_IDX)
				continue;
			if (do_free)
				m_state[i] = ST_FREE;
			else if ((hit1 || hit2) && m_state[i] == ST_PENDING)
			begin
				m_data[i]  = hit2 ? cdb2_value : cdb1_value; // same tag on both, cdb2 wins
				m_state[i] = ST_READY;
			end
			else if (((v1 && i1 == i) || (v2 && i2 == i)) && m_state[i] == ST_FREE)
				m_state[i] = ST_PENDING;
		end
	endfunction

	//////////////////////////////
	// comparison
	//////////////////////////////

	task automatic compare_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("FAILED %s expected %0h got %0h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic check_outputs();
		logic             v1, v2, full, ev;
		logic [IDX_W-1:0] i1, i2;
		data_t            ed;
		expected_alloc(alloc_req1, alloc_req2, v1, i1, v2, i2, full);
		compare_value("alloc_valid1", v1, alloc_valid1);
		compare_value("alloc_idx1", i1, alloc_idx1);
		compare_value("alloc_valid2", v2, alloc_valid2);
		compare_value("alloc_idx2", i2, alloc_idx2);
		compare_value("prf_full", full, prf_full);
		expected_read(opa1_idx, ed, ev);
		compare_value("opa1_value", ed, opa1_value);
		compare_value("opa1_valid", ev, opa1_valid);
		expected_read(opb1_idx, ed, ev);
		compare_value("opb1_value", ed, opb1_value);
		compare_value("opb1_valid", ev, opb1_valid);
		expected_read(opa2_idx, ed, ev);
		compare_value("opa2_value", ed, opa2_value);
		compare_value("opa2_valid", ev, opa2_valid);
		expected_read(opb2_idx, ed, ev);
		compare_value("opb2_value", ed, opb2_value);
		compare_value("opb2_valid", ev, opb2_valid);
		expected_read(wb_idx, ed, ev);
		compare_value("wb_value", ev ? ed : data_t'(0), wb_value); // not ready reads zero
		model_update(v1, i1, v2, i2); // grants of this cycle land at the coming edge
	endtask

	// outputs have settled 8 ns after the edge and the inputs moved at 1 ns
	initial
	begin : compare_proc
		forever
		begin
			@(posedge clock);
			#8;
			if (reset)
				model_reset();
			else
				check_outputs();
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic idle_inputs();
		{alloc_req1, alloc_req2, cdb1_valid, cdb2_valid} = '0;
		{free1_valid, free2_valid, flush_valid, flush_list} = '0;
		{cdb1_tag, cdb2_tag, free1_idx, free2_idx} = '0;
		{cdb1_value, cdb2_value} = '0;
		{opa1_idx, opb1_idx, opa2_idx, opb2_idx, wb_idx} = '0;
	endtask

	// points the four operand ports and the writeback port at new entries
	task automatic set_read_idx(input int a1, input int b1, input int a2, input int b2,
		input int wb);
		opa1_idx = IDX_W'(a1);
		opb1_idx = IDX_W'(b1);
		opa2_idx = IDX_W'(a2);
		opb2_idx = IDX_W'(b2);
		wb_idx   = IDX_W'(wb);
	endtask

	initial
	begin
		int fill_wait;
		void'($urandom(1158));
		errors = 0;
		checks = 0;
		reset = 1'b1;
		idle_inputs();
		repeat (RESET_CYCLES) @(posedge clock);
		#1 reset = 1'b0;

		// fresh file, only the zero register is ready
		set_read_idx(0, 1, ZERO_IDX, PRF_SIZE - 1, ZERO_IDX);
		next_cycle();

		alloc_req1 = 1'b1; // port 1 alone
		next_cycle();
		alloc_req1 = 1'b0; // port 2 alone
		alloc_req2 = 1'b1;
		next_cycle();
		alloc_req1 = 1'b1;
		fill_wait = 0;
		while (!prf_full && fill_wait < PRF_SIZE)
		begin
			next_cycle();
			fill_wait++;
		end
		if (!prf_full)
		begin
			errors++;
			$display("prf_full never rose while both ports kept allocating");
		end
		next_cycle(); // requests against a full file see valid low
		{alloc_req1, alloc_req2} = '0;

		// results on both buses, then both buses on one tag
		cdb1_valid = 1'b1;
		cdb1_tag   = 1;
		cdb1_value = {$urandom, $urandom};
		cdb2_valid = 1'b1;
		cdb2_tag   = 2;
		cdb2_value = {$urandom, $urandom};
		set_read_idx(1, 2, 3, 4, 3);
		next_cycle();
		cdb1_tag   = 3;
		cdb1_value = {$urandom, $urandom};
		cdb2_tag   = 3;
		cdb2_value = {$urandom, $urandom};
		next_cycle();
		{cdb1_valid, cdb2_valid} = '0;
		next_cycle();

		// retire frees, then a free racing a write on entry 10
		free1_valid = 1'b1;
		free1_idx   = 5;
		free2_valid = 1'b1;
		free2_idx   = 9;
		next_cycle();
		free1_idx   = 10;
		free2_valid = 1'b0;
		cdb1_valid  = 1'b1;
		cdb1_tag    = 10;
		cdb1_value  = {$urandom, $urandom};
		set_read_idx(5, 10, 3, 4, 10);
		next_cycle();
		free1_valid = 1'b0;
		cdb1_tag = 5; // entry 5 is free so this write is dropped
		next_cycle();
		cdb1_valid = 1'b0;
		{alloc_req1, alloc_req2} = 2'b11; // reuse 5 and 9
		next_cycle();
		alloc_req2 = 1'b0; // then 10
		next_cycle();
		alloc_req1 = 1'b0;

		// entries inside the flush range and entry 31 just past it get values first
		cdb1_valid = 1'b1;
		cdb1_tag   = 20;
		cdb1_value = {$urandom, $urandom};
		cdb2_valid = 1'b1;
		cdb2_tag   = 25;
		cdb2_value = {$urandom, $urandom};
		set_read_idx(20, 25, 30, 31, 25);
		next_cycle();
		cdb1_tag   = 30;
		cdb1_value = {$urandom, $urandom};
		cdb2_tag   = 31;
		cdb2_value = {$urandom, $urandom};
		next_cycle();
		{cdb1_valid, cdb2_valid} = '0;

		// mispredict flush of entries 20 to 30, entry 31 keeps its value
		flush_valid = 1'b1;
		flush_list = PRF_SIZE'(64'h7ff) << 20;
		next_cycle();
		flush_valid = 1'b0;
		{alloc_req1, alloc_req2} = 2'b11; // flushed entries are the only free ones
		next_cycle();
		{alloc_req1, alloc_req2} = '0;
		next_cycle();

		//////////////////////////////
		// random mix
		//////////////////////////////

		for (int c = 0; c < RAND_CYCLES; c++)
		begin
			alloc_req1 = $urandom_range(0, 1);
			alloc_req2 = $urandom_range(0, 1);
			cdb1_valid = ($urandom_range(0, 3) != 0);
			cdb1_tag   = IDX_W'($urandom);
			cdb1_value = {$urandom, $urandom};
			cdb2_valid = ($urandom_range(0, 3) != 0);
			cdb2_tag   = ($urandom_range(0, 7) == 0) ? cdb1_tag : IDX_W'($urandom);
			cdb2_value = {$urandom, $urandom};
			free1_valid = ($urandom_range(0, 2) == 0);
			free1_idx   = IDX_W'($urandom);
			free2_valid = ($urandom_range(0, 2) == 0);
			free2_idx   = IDX_W'($urandom);
			flush_valid = ($urandom_range(0, 63) == 0); // rare, a flush empties a lot
			flush_list  = {$urandom, $urandom} & {$urandom, $urandom};
			opa1_idx = IDX_W'($urandom);
			opb1_idx = IDX_W'($urandom);
			opa2_idx = IDX_W'($urandom);
			opb2_idx = IDX_W'($urandom);
			wb_idx   = IDX_W'($urandom);
			next_cycle();
		end

		idle_inputs();
		next_cycle();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// ends a hung run after twice the expected length
	initial
	begin
		#(2 * TOTAL_CYCLES * 10);
		$display("watchdog expired, run did not finish in time");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== sim.f ====
logic/prf_cfg_pkg.sv
logic/prf_state_pkg.sv
logic/prf_alloc.sv
logic/prf_entries.sv
logic/prf_read.sv
logic/prf_top.sv
dv/tb_prf_top.sv
